/* Makefile */
TOP = tb_uart_subsys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

/* sim.f */
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_mmio.sv
uart_subsys.sv
tb_uart_subsys.sv

/* tb_uart_subsys.sv */
// Testbench for uart_subsys. Inputs change on the falling clock edge.
// Each row runs at its own divisor; random bytes come from a 16-bit Galois LFSR.
// Every wait is a bounded loop, so a dead DUT ends in a timeout report.
`timescale 1ns/1ps
`default_nettype none

module tb_uart_subsys import uart_pkg::*; ();

localparam logic [31:0] BASE      = 32'h4000_0000;
localparam logic [31:0] IDLE_ADDR = 32'h0000_0000;    // Off the UART page.
localparam logic [31:0] FLAG_MASK = 32'h0000_0100;    // tx_ready and rx_valid.

typedef struct packed {
    logic [31:0] div;
    logic [7:0]  data;
    logic        rnd;
    logic        loopback;
    logic        abort;
} row_t;

logic         clk;
logic         rst_n;
logic [31:0]  rd_addr;
logic [31:0]  rd_data;
uart_wr_req_t wr_req;
logic         rx_line;
logic         tx_line;
logic         ser_rx;
logic         loopback;
logic [15:0]  lfsr;
row_t         rows[$];
int           checks;
int           errors;

assign rx_line = loopback ? tx_line : ser_rx;

always #4 clk = ~clk;

uart_subsys #(
    .BASE (BASE)
) u_uart_subsys (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .wr_req_i  (wr_req),
    .rx_i      (rx_line),
    .tx_o      (tx_line)
);

function automatic logic [31:0] reg_addr(input uart_reg_e r);
    return BASE | {28'h0, r, 2'b00};
endfunction

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

task automatic random_byte(output logic [7:0] b);
    int i;
    b = '0;
    for (i = 0; i < 8; i++) begin
        lfsr = lfsr_next(lfsr);    // One step per bit.
        b    = {b[6:0], lfsr[0]};
    end
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
    wr_req.addr = addr;
    wr_req.data = data;
    wr_req.strb = strb;
    @(negedge clk);
    wr_req = '0;
endtask

// Read data is registered, so it is taken one cycle after the address.
task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    rd_addr = addr;
    @(negedge clk);
    data    = rd_data;
    rd_addr = IDLE_ADDR;
endtask

task automatic expect_reg(input uart_reg_e r, input logic [31:0] exp);
    logic [31:0] word;
    bus_read(reg_addr(r), word);
    check_value(r.name(), word, exp);
endtask

task automatic wait_flag(input uart_reg_e r, input logic want, input int limit,
                         output logic [31:0] word);
    int   n;
    logic hit;
    n = 0;
    bus_read(reg_addr(r), word);
    hit = (((word & FLAG_MASK) != 0) == want);
    while (!hit && n < limit) begin
        bus_read(reg_addr(r), word);
        hit = (((word & FLAG_MASK) != 0) == want);
        n++;
    end
    checks++;
    assert (hit) else begin
        $display("Timeout: flag in %s did not read %0b within %0d polls", r.name(), want, limit);
        errors++;
    end
endtask

task automatic wait_line(input logic level, input int limit);
    int n;
    n = 0;
    while (tx_line !== level && n < limit) begin
        @(negedge clk);
        n++;
    end
    checks++;
    assert (tx_line === level) else begin
        $display("Timeout: tx_o did not go to %0b within %0d cycles", level, limit);
        errors++;
    end
endtask

// Samples at each bit centre; bits[0] holds the start bit.
task automatic sample_frame(input int div, output logic [9:0] bits);
    int i;
    bits = '1;
    wait_line(1'b0, 8);
    if (tx_line === 1'b0) begin
        repeat (div / 2) @(negedge clk);
        for (i = 0; i < 10; i++) begin
            bits = {tx_line, bits[9:1]};
            if (i < 9) begin
                repeat (div) @(negedge clk);
            end
        end
    end
endtask

task automatic send_serial(input logic [7:0] data, input int div);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, data, 1'b0};
    for (i = 0; i < 10; i++) begin
        ser_rx = frame[0];
        frame  = frame >> 1;
        repeat (div) @(negedge clk);
    end
endtask

task automatic add_row(input int div, input logic [7:0] data, input logic rnd,
                       input logic loop, input logic abort);
    row_t row;
    row.div      = div;
    row.data     = data;
    row.rnd      = rnd;
    row.loopback = loop;
    row.abort    = abort;
    rows.push_back(row);
endtask

task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
        $display("test %-10s pass", name);
    end else begin
        $display("test %-10s fail, %0d errors", name, errors - err0);
    end
endtask

task automatic run_row(input row_t row, input int idx);
    int          div;
    int          err0;
    logic [7:0]  tx_byte;
    logic [7:0]  rx_byte;
    logic [9:0]  bits;
    logic [31:0] word;
    logic [31:0] busy_word;
    div      = row.div;
    err0     = errors;
    loopback = row.loopback;
    if (row.rnd) begin
        random_byte(tx_byte);
    end else begin
        tx_byte = row.data;
    end
    bus_write(reg_addr(CTRL_0), row.div, 4'hF);
    bus_write(reg_addr(CTRL_1), 32'd1, 4'hF);
    if (row.abort) begin
        // Leave one received byte unread, so rx_valid is set at the abort.
        loopback = 1'b0;
        send_serial(8'hA5, div);
        repeat (div) @(negedge clk);
        loopback = row.loopback;
        // All-zero byte keeps the line low up to the abort.
        bus_write(reg_addr(DATA_TX), 32'h0, 4'hF);
        wait_line(1'b0, 8);
        repeat (4 * div) @(negedge clk);    // Well inside the data bits.
        bus_write(reg_addr(CTRL_1), 32'd0, 4'hF);
        wait_line(1'b1, 3);
        bus_read(reg_addr(DATA_TX), word);
        check_value("tx_ready", 32'(word[8]), 0);
        bus_read(reg_addr(DATA_RX), word);
        check_value("rx_valid", 32'(word[8]), 0);
        bus_write(reg_addr(CTRL_1), 32'd1, 4'hF);
    end
    bus_write(reg_addr(DATA_TX), 32'(tx_byte), 4'hF);
    fork
        sample_frame(div, bits);
        begin
            repeat (3) @(negedge clk);
            bus_read(reg_addr(DATA_TX), busy_word);
            check_value("tx_ready", 32'(busy_word[8]), 0);
            check_value("tx_data", 32'(busy_word[7:0]), 32'(tx_byte));
        end
    join
    check_value("frame", 32'(bits), 32'({1'b1, tx_byte, 1'b0}));
    wait_flag(DATA_TX, 1'b1, 2 * div + 8, word);
    if (row.loopback) begin
        rx_byte = tx_byte;
    end else begin
        random_byte(rx_byte);
        send_serial(rx_byte, div);
    end
    // The read that sees rx_valid also acknowledges it.
    wait_flag(DATA_RX, 1'b1, 4 * div + 16, word);
    check_value("rx_data", 32'(word[7:0]), 32'(rx_byte));
    wait_flag(DATA_RX, 1'b0, 8, word);
    bus_write(reg_addr(CTRL_1), 32'd0, 4'hF);
    report_test($sformatf("row %0d", idx), err0);
endtask

initial begin
    logic [31:0] word;
    int          err0;
    clk      = 1'b0;
    rst_n    = 1'b0;
    rd_addr  = IDLE_ADDR;
    wr_req   = '0;
    ser_rx   = 1'b1;
    loopback = 1'b0;
    lfsr     = 16'd94;
    checks   = 0;
    errors   = 0;

    add_row(4,  8'h55, 1'b0, 1'b1, 1'b0);
    add_row(5,  8'hA3, 1'b0, 1'b0, 1'b0);
    add_row(8,  8'h00, 1'b1, 1'b1, 1'b0);
    add_row(7,  8'hFF, 1'b0, 1'b0, 1'b0);
    add_row(16, 8'h3C, 1'b0, 1'b1, 1'b1);
    add_row(10, 8'h00, 1'b1, 1'b0, 1'b1);
    add_row(6,  8'h81, 1'b0, 1'b1, 1'b0);

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    err0 = errors;
    check_value("tx_o", 32'(tx_line), 1);
    expect_reg(CTRL_0, 0);
    expect_reg(CTRL_1, 0);
    expect_reg(DATA_TX, 0);
    expect_reg(DATA_RX, 0);
    report_test("reset", err0);

    err0 = errors;
    bus_write(reg_addr(CTRL_0), 32'h1234_5678, 4'hF);
    expect_reg(CTRL_0, 32'h1234_5678);
    bus_write(reg_addr(CTRL_1), 32'hFFFF_FFFF, 4'hF);
    expect_reg(CTRL_1, 32'h1);
    bus_write(reg_addr(CTRL_0), 32'hDEAD_BEEF, 4'h0);
    expect_reg(CTRL_0, 32'h1234_5678);
    bus_write(reg_addr(CTRL_0) + 32'h100, 32'hDEAD_BEEF, 4'hF);    // Next page up.
    expect_reg(CTRL_0, 32'h1234_5678);
    bus_read(32'h5000_0004, word);
    check_value("rd_data_o", word, 32'h1234_5678);
    bus_write(reg_addr(CTRL_1), 32'd0, 4'hF);
    report_test("registers", err0);

    foreach (rows[r]) begin
        run_row(rows[r], r);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

endmodule

`default_nettype wire

/* uart_mmio.sv */
// UART register block on one 256-byte page at BASE.
// Read data is registered and holds when the page does not match.
// Writes need any strobe set; partial-word merges are not supported.
`timescale 1ns/1ps
`default_nettype none

module uart_mmio import uart_pkg::*; #(
    parameter logic [31:0] BASE = 32'h4000_0000
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic [31:0]  rd_addr_i,
    output logic [31:0]  rd_data_o,
    input  uart_wr_req_t wr_req_i,
    input  logic         rx_i,
    output logic         tx_o
);

uart_ctrl0_t   ctrl0_q;
logic          en_q;
logic [7:0]    tx_data_q;
logic          tx_start_q;
logic          rx_ack_q;
logic [31:0]   rd_data_q;

uart_ctrl1_t   ctrl1;
uart_data_tx_t data_tx;
uart_data_rx_t data_rx;
logic [31:0]   rd_word;

logic          tx_ready;
logic          rx_valid;
logic [7:0]    rx_data;

logic          rd_hit;
logic          wr_hit;
uart_reg_e     rd_reg;
uart_reg_e     wr_reg;

assign rd_hit = (rd_addr_i[31:8] == BASE[31:8]);
assign wr_hit = (wr_req_i.addr[31:8] == BASE[31:8]) && (|wr_req_i.strb);
assign rd_reg = uart_reg_e'(rd_addr_i[3:2]);
assign wr_reg = uart_reg_e'(wr_req_i.addr[3:2]);

assign rd_data_o = rd_data_q;

always_comb begin
    ctrl1            = '0;
    ctrl1.en         = en_q;
    data_tx          = '0;
    data_tx.tx_ready = tx_ready;
    data_tx.tx_data  = tx_data_q;
    data_rx          = '0;
    data_rx.rx_valid = rx_valid;
    data_rx.rx_data  = rx_data;

    case (rd_reg)
        CTRL_0:  rd_word = ctrl0_q;
        CTRL_1:  rd_word = ctrl1;
        DATA_TX: rd_word = data_tx;
        default: rd_word = data_rx;
    endcase
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ctrl0_q   <= '0;
        en_q      <= 1'b0;
        tx_data_q <= '0;
        rd_data_q <= '0;
    end else begin
        if (rd_hit) begin
            rd_data_q <= rd_word;
        end
        if (wr_hit) begin
            case (wr_reg)
                CTRL_0:  ctrl0_q   <= uart_ctrl0_t'(wr_req_i.data);
                CTRL_1:  en_q      <= wr_req_i.data[0];
                DATA_TX: tx_data_q <= wr_req_i.data[7:0];
                default: ;    // DATA_RX is read-only.
            endcase
        end
    end
end

// Start request holds until the serializer takes it.
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        tx_start_q <= 1'b0;
    end else if (!en_q) begin
        tx_start_q <= 1'b0;
    end else if (wr_hit && (wr_reg == DATA_TX)) begin
        tx_start_q <= 1'b1;
    end else if (tx_ready) begin
        tx_start_q <= 1'b0;
    end
end

// Ack stays up until the held byte is released.
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        rx_ack_q <= 1'b0;
    end else if (!rx_valid) begin
        rx_ack_q <= 1'b0;
    end else if (rd_hit && (rd_reg == DATA_RX)) begin
        rx_ack_q <= 1'b1;
    end
end

uart_tx u_tx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .en_i       (en_q),
    .baud_div_i (ctrl0_q.baud_div),
    .start_i    (tx_start_q),
    .data_i     (tx_data_q),
    .ready_o    (tx_ready),
    .tx_o       (tx_o)
);

uart_rx u_rx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .en_i       (en_q),
    .baud_div_i (ctrl0_q.baud_div),
    .ack_i      (rx_ack_q),
    .rx_i       (rx_i),
    .valid_o    (rx_valid),
    .data_o     (rx_data)
);

a_start_needs_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !en_q |=> !$rose(tx_start_q));

endmodule

`default_nettype wire

/* uart_pkg.sv */
// Register map and bus types for the UART peripheral.
// All register layouts are fixed at 32 bits.
// Reserved fields read as zero and ignore writes.
`default_nettype none

package uart_pkg;

    localparam int BAUD_W = 32;    // Divisor width, in bits.

    // Word index, taken from address bits 3:2.
    typedef enum logic [1:0] {
        CTRL_0  = 2'h0,
        CTRL_1  = 2'h1,
        DATA_TX = 2'h2,
        DATA_RX = 2'h3
    } uart_reg_e;

    typedef struct packed {
        logic [31:0] baud_div;     // Bit period in clocks, at least 4.
    } uart_ctrl0_t;

    typedef struct packed {
        logic [30:0] rsvd;
        logic        en;           // Clearing it acts as a soft reset.
    } uart_ctrl1_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic        tx_ready;
        logic [7:0]  tx_data;
    } uart_data_tx_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic        rx_valid;
        logic [7:0]  rx_data;
    } uart_data_rx_t;

    // One write request, acted on when any strobe is set.
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } uart_wr_req_t;

endpackage

`default_nettype wire

/* uart_rx.sv */
// 8N1 deserializer with a two-flop input synchronizer.
// baud_div_i must be at least 4; the start bit is rechecked at mid-bit.
// A new byte overwrites an unacknowledged one, and no overrun is flagged.
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              en_i,
    input  logic [BAUD_W-1:0] baud_div_i,
    input  logic              ack_i,
    input  logic              rx_i,
    output logic              valid_o,
    output logic [7:0]        data_o
);

typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_e;

rx_state_e         state_q;
logic [1:0]        sync_q;
logic              rx_prev_q;
logic [BAUD_W-1:0] cnt_q;
logic [2:0]        bit_q;
logic [7:0]        shift_q;
logic [7:0]        data_q;
logic              valid_q;
logic              rx_s;
logic              bit_end;
logic              frame_done;

assign rx_s       = sync_q[1];
assign bit_end    = (cnt_q == '0);
assign frame_done = (state_q == STOP) && bit_end && rx_s;   // Good stop bit.
assign valid_o    = valid_q;
assign data_o     = data_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        sync_q    <= 2'b11;
        rx_prev_q <= 1'b1;
    end else begin
        sync_q    <= {sync_q[0], rx_i};
        rx_prev_q <= rx_s;
    end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q <= IDLE;
        cnt_q   <= '0;
        bit_q   <= '0;
        data_q  <= '0;
        valid_q <= 1'b0;
    end else if (!en_i) begin
        state_q <= IDLE;
        cnt_q   <= '0;
        bit_q   <= '0;
        valid_q <= 1'b0;
    end else begin
        case (state_q)
            IDLE: begin
                if (rx_prev_q && !rx_s) begin
                    cnt_q   <= (baud_div_i >> 1) - 1'b1;    // Half a bit.
                    state_q <= START;
                end
            end
            START: begin
                if (!bit_end) begin
                    cnt_q <= cnt_q - 1'b1;
                end else if (!rx_s) begin
                    cnt_q   <= baud_div_i - 1'b1;
                    bit_q   <= '0;
                    state_q <= DATA;
                end else begin
                    state_q <= IDLE;    // Glitch, not a start bit.
                end
            end
            DATA: begin
                if (bit_end) begin
                    cnt_q <= baud_div_i - 1'b1;
                    bit_q <= bit_q + 1'b1;
                    if (bit_q == 3'd7) begin
                        state_q <= STOP;
                    end
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
            STOP: begin
                if (bit_end) begin
                    state_q <= IDLE;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        endcase

        // A completing frame wins over the acknowledge.
        if (frame_done) begin
            data_q  <= shift_q;
            valid_q <= 1'b1;
        end else if (ack_i) begin
            valid_q <= 1'b0;
        end
    end
end

// LSB arrives first.
always_ff @(posedge clk_i) begin
    if ((state_q == DATA) && bit_end) begin
        shift_q <= {rx_s, shift_q[7:1]};
    end
end

a_held_byte: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !frame_done) |=> $stable(data_o));

endmodule

`default_nettype wire

/* uart_subsys.sv */
// UART subsystem with a plain read port and a plain write port.
// BASE selects the 256-byte register page; its low 8 bits are ignored.
`timescale 1ns/1ps
`default_nettype none

module uart_subsys import uart_pkg::*; #(
    parameter logic [31:0] BASE = 32'h4000_0000
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic [31:0]  rd_addr_i,
    output logic [31:0]  rd_data_o,
    input  uart_wr_req_t wr_req_i,
    input  logic         rx_i,
    output logic         tx_o
);

uart_mmio #(
    .BASE (BASE)
) u_mmio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o),
    .wr_req_i  (wr_req_i),
    .rx_i      (rx_i),
    .tx_o      (tx_o)
);

endmodule

`default_nettype wire

/* uart_tx.sv */
// 8N1 serializer, one frame per start_i seen while idle.
// baud_div_i is the bit period in clocks and must be at least 4.
// Dropping en_i aborts the frame at the next edge and holds tx_o high.
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              en_i,
    input  logic [BAUD_W-1:0] baud_div_i,
    input  logic              start_i,
    input  logic [7:0]        data_i,
    output logic              ready_o,
    output logic              tx_o
);

typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_e;

tx_state_e         state_q;
logic [BAUD_W-1:0] cnt_q;
logic [2:0]        bit_q;
logic [7:0]        shift_q;
logic              tx_q;
logic              bit_end;

assign bit_end = (cnt_q == '0);
assign ready_o = en_i && (state_q == IDLE);
assign tx_o    = tx_q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q <= IDLE;
        cnt_q   <= '0;
        bit_q   <= '0;
        tx_q    <= 1'b1;
    end else if (!en_i) begin
        state_q <= IDLE;
        cnt_q   <= '0;
        bit_q   <= '0;
        tx_q    <= 1'b1;            // Line idles high.
    end else begin
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    cnt_q   <= baud_div_i - 1'b1;
                    tx_q    <= 1'b0;
                    state_q <= START;
                end
            end
            START: begin
                if (bit_end) begin
                    cnt_q   <= baud_div_i - 1'b1;
                    bit_q   <= '0;
                    tx_q    <= shift_q[0];
                    state_q <= DATA;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
            DATA: begin
                if (bit_end) begin
                    cnt_q <= baud_div_i - 1'b1;
                    bit_q <= bit_q + 1'b1;
                    if (bit_q == 3'd7) begin
                        tx_q    <= 1'b1;    // Stop bit.
                        state_q <= STOP;
                    end else begin
                        tx_q <= shift_q[0];
                    end
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
            STOP: begin
                if (bit_end) begin
                    state_q <= IDLE;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        endcase
    end
end

// Next data bit always sits in shift_q[0].
always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
        if (start_i) begin
            shift_q <= data_i;
        end
    end else if (bit_end) begin
        shift_q <= {1'b0, shift_q[7:1]};
    end
end

a_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == IDLE) |-> tx_o);

// Disabled core is never ready and is idle one edge later.
a_off_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !en_i |-> !ready_o ##1 (state_q == IDLE));

endmodule

`default_nettype wire
